// File: wb_sim_defs.svh
`ifndef WB_SIM_DEFS_SVH
`define WB_SIM_DEFS_SVH

// ----------------------------------------------------------------------
// bus widths
// ----------------------------------------------------------------------
`define WB_ADDR_W      32              // byte address width
`define WB_DATA_W      32              // data word width
`define WB_SEL_W       4               // one select bit per data byte

// ----------------------------------------------------------------------
// address map
// ----------------------------------------------------------------------
// data region, plain word memory
`define DMEM_BASE      32'h8000_0000   // first byte of data region
`define DMEM_SIZE      8192            // region size in bytes
`define DMEM_LATENCY   8               // extra read/ack delay in cycles

// small IO region, much slower than the data region
`define IOMEM_BASE     32'hF000_0000   // first byte of IO region
`define IOMEM_SIZE     32              // region size in bytes
`define IOMEM_LATENCY  128             // extra read/ack delay in cycles

// interrupt trigger register, decoded as a single word
`define IRQ_TRIG_ADDR  32'hFF00_0000   // only full-word writes land here

// ----------------------------------------------------------------------
// bus timeout
// ----------------------------------------------------------------------
`define WB_TIMEOUT     256             // cycles without ack before err pulse

`endif

// File: wb_sim_pkg.sv
`default_nettype none

package wb_sim_pkg;

    `include "wb_sim_defs.svh"

    // one bus word seen two ways
    // raw for plain data, fld for the trigger register bits
    typedef union packed {
        logic [`WB_DATA_W-1:0] raw;            // plain write data
        struct packed {
            logic [`WB_DATA_W-13:0] rsvd_hi;   // bits 31..12 ignored
            logic                   mext;      // bit 11 machine external irq
            logic [6:0]             rsvd_mid;  // bits 10..4 ignored
            logic                   msw;       // bit 3 machine software irq
            logic [2:0]             rsvd_lo;   // bits 2..0 ignored
        } fld;
    } irq_word_u;

endpackage : wb_sim_pkg

`default_nettype wire

// File: wb_slave_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_sim_defs.svh"

// one fabric to target link, classic wishbone
interface wb_slave_if;

    logic [`WB_ADDR_W-1:0] adr;    // byte address, broadcast
    logic [`WB_DATA_W-1:0] dat_w;  // write data, broadcast
    logic [`WB_DATA_W-1:0] dat_r;  // read data, zero unless ack
    logic                  we;     // write enable
    logic [`WB_SEL_W-1:0]  sel;    // byte selects
    logic                  stb;    // strobe, only on the addressed target
    logic                  cyc;    // valid cycle, broadcast
    logic                  ack;    // transfer acknowledge

    // fabric side drives the request
    modport fabric (
        output adr,
        output dat_w,
        output we,
        output sel,
        output stb,
        output cyc,
        input  dat_r,
        input  ack
    );

    // target side answers
    modport target (
        input  adr,
        input  dat_w,
        input  we,
        input  sel,
        input  stb,
        input  cyc,
        output dat_r,
        output ack
    );

endinterface : wb_slave_if

`default_nettype wire

// File: wb_fabric_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_sim_defs.svh"

module wb_fabric_ctrl (
    input  logic                  clk_gen,
    input  logic                  rst_gen,    // async, active low
    input  logic [`WB_ADDR_W-1:0] wb_adr_i,
    input  logic [`WB_DATA_W-1:0] wb_dat_i,
    output logic [`WB_DATA_W-1:0] wb_dat_o,
    input  logic                  wb_we_i,
    input  logic [`WB_SEL_W-1:0]  wb_sel_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_cyc_i,
    output logic                  wb_ack_o,
    output logic                  wb_err_o,
    wb_slave_if.fabric            bus_dmem,
    wb_slave_if.fabric            bus_io,
    wb_slave_if.fabric            bus_irq
);

    localparam logic [`WB_ADDR_W-1:0] DMEM_LO  = `DMEM_BASE;
    localparam logic [`WB_ADDR_W-1:0] DMEM_HI  = `WB_ADDR_W'(`DMEM_BASE + `DMEM_SIZE);
    localparam logic [`WB_ADDR_W-1:0] IOMEM_LO = `IOMEM_BASE;
    localparam logic [`WB_ADDR_W-1:0] IOMEM_HI = `WB_ADDR_W'(`IOMEM_BASE + `IOMEM_SIZE);
    localparam int                    TMO      = `WB_TIMEOUT;
    localparam int                    CNT_W    = $clog2(TMO + 1);

    logic             hit_dmem;   // address inside data region
    logic             hit_io;     // address inside IO region
    logic             hit_irq;    // exact trigger word
    logic             pending;    // request open and not answered yet
    logic [CNT_W-1:0] tmo_cnt;    // cycles spent waiting
    logic             err_q;

    // ----------------------------------------------------------------------
    // address decode
    // ----------------------------------------------------------------------
    assign hit_dmem = (wb_adr_i >= DMEM_LO) && (wb_adr_i < DMEM_HI);
    assign hit_io   = (wb_adr_i >= IOMEM_LO) && (wb_adr_i < IOMEM_HI);
    assign hit_irq  = (wb_adr_i == `IRQ_TRIG_ADDR);

    // ----------------------------------------------------------------------
    // request broadcast with the strobe only to the hit target
    // ----------------------------------------------------------------------
    assign bus_dmem.adr   = wb_adr_i;
    assign bus_dmem.dat_w = wb_dat_i;
    assign bus_dmem.we    = wb_we_i;
    assign bus_dmem.sel   = wb_sel_i;
    assign bus_dmem.cyc   = wb_cyc_i;
    assign bus_dmem.stb   = wb_stb_i & hit_dmem;

    assign bus_io.adr     = wb_adr_i;
    assign bus_io.dat_w   = wb_dat_i;
    assign bus_io.we      = wb_we_i;
    assign bus_io.sel     = wb_sel_i;
    assign bus_io.cyc     = wb_cyc_i;
    assign bus_io.stb     = wb_stb_i & hit_io;

    assign bus_irq.adr    = wb_adr_i;
    assign bus_irq.dat_w  = wb_dat_i;
    assign bus_irq.we     = wb_we_i;
    assign bus_irq.sel    = wb_sel_i;
    assign bus_irq.cyc    = wb_cyc_i;
    assign bus_irq.stb    = wb_stb_i & hit_irq;

    // targets keep dat_r at zero without ack, so a plain OR merges them
    assign wb_dat_o = bus_dmem.dat_r | bus_io.dat_r | bus_irq.dat_r;
    assign wb_ack_o = bus_dmem.ack | bus_io.ack | bus_irq.ack;

    // ----------------------------------------------------------------------
    // bus timeout
    // ----------------------------------------------------------------------
    assign pending = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            tmo_cnt <= '0;
            err_q   <= 1'b0;
        end else begin
            err_q <= 1'b0;                          // single cycle pulse
            if (!pending) begin
                tmo_cnt <= '0;                      // answered or idle
            end else if (tmo_cnt == CNT_W'(TMO - 1)) begin
                tmo_cnt <= '0;
                err_q   <= 1'b1;                    // seen TMO edges after start
            end else begin
                tmo_cnt <= tmo_cnt + 1'b1;
            end
        end
    end

    assign wb_err_o = err_q;

    // the address map must keep the three regions apart
    a_one_target: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        $onehot0({bus_dmem.stb, bus_io.stb, bus_irq.stb}));

    // target latencies must stay below the timeout
    a_ack_err_excl: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        !(wb_ack_o && wb_err_o));

endmodule : wb_fabric_ctrl

`default_nettype wire

// File: wb_latency_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_sim_defs.svh"

module wb_latency_mem #(
    parameter int MEM_BYTES = 8192,   // region size in bytes, power of two
    parameter int LATENCY   = 8       // extra delay stages, at least 1
) (
    input  logic       clk_gen,
    input  logic       rst_gen,       // async, active low
    wb_slave_if.target bus
);

    localparam int WORDS = MEM_BYTES / `WB_SEL_W;
    localparam int IDX_W = $clog2(WORDS);
    localparam int OFS_W = $clog2(`WB_SEL_W);   // byte offset bits inside a word

    logic [`WB_DATA_W-1:0] mem [WORDS];          // word array
    logic [IDX_W-1:0]      word_idx;
    logic                  req;                  // cyc and stb seen together
    logic [LATENCY-1:0]    ack_pipe;             // one token per strobed cycle
    logic [`WB_DATA_W-1:0] rd_pipe [LATENCY];    // read data travelling with ack
    logic                  ack_q;                // output register
    logic [`WB_DATA_W-1:0] rd_q;

    assign word_idx = bus.adr[IDX_W+OFS_W-1:OFS_W];
    assign req      = bus.cyc & bus.stb;

    // ----------------------------------------------------------------------
    // storage and read data chain
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_gen) begin
        if (req && bus.we) begin
            for (int b = 0; b < `WB_SEL_W; b++) begin
                if (bus.sel[b]) begin
                    mem[word_idx][b*8 +: 8] <= bus.dat_w[b*8 +: 8];
                end
            end
        end
        rd_pipe[0] <= mem[word_idx];                 // old word on a write edge
        for (int i = 1; i < LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        rd_q <= rd_pipe[LATENCY-1];
    end

    // ----------------------------------------------------------------------
    // acknowledge chain
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            ack_pipe <= '0;
            ack_q    <= 1'b0;
        end else begin
            ack_pipe[0] <= req;                      // request start
            for (int i = 1; i < LATENCY; i++) begin
                ack_pipe[i] <= ack_pipe[i-1] & bus.cyc;  // dropped cyc flushes
            end
            ack_q <= ack_pipe[LATENCY-1] & bus.cyc;
        end
    end

    // output reg may still be set while the master drops cyc after ack
    assign bus.ack   = ack_q & bus.cyc;
    assign bus.dat_r = bus.ack ? rd_q : '0;          // zero lets the fabric OR

    // one low cyc edge empties every stage, so no late ack can follow
    a_flush_on_cyc_low: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        !bus.cyc |=> ((ack_pipe == '0) && !bus.ack));

endmodule : wb_latency_mem

`default_nettype wire

// File: wb_irq_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module wb_irq_trigger
    import wb_sim_pkg::*;
(
    input  logic       clk_gen,
    input  logic       rst_gen,      // async, active low
    wb_slave_if.target bus,
    output logic       msw_irq_o,    // machine software interrupt
    output logic       mext_irq_o    // machine external interrupt
);

    irq_word_u wr_word;              // write data through the bit view
    logic      wr_full;              // strobed write with all bytes selected
    logic      ack_q;

    assign wr_word.raw = bus.dat_w;
    assign wr_full     = bus.cyc & bus.stb & bus.we & (&bus.sel);

    // ----------------------------------------------------------------------
    // trigger register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            ack_q      <= 1'b0;
            msw_irq_o  <= 1'b0;
            mext_irq_o <= 1'b0;
        end else begin
            ack_q <= wr_full;                        // reads and partial writes stay silent
            if (wr_full) begin
                msw_irq_o  <= wr_word.fld.msw;       // bit 3
                mext_irq_o <= wr_word.fld.mext;      // bit 11
            end
        end
    end

    assign bus.ack   = ack_q & bus.cyc;              // no stale ack once cyc drops
    assign bus.dat_r = '0;                           // write only

    // ack follows a full-word write one edge earlier and the lines hold its bits 3 and 11
    a_ack_after_write: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        bus.ack |-> $past(bus.cyc && bus.stb && bus.we && (&bus.sel))
                    && (msw_irq_o == $past(bus.dat_w[3]))
                    && (mext_irq_o == $past(bus.dat_w[11])));

endmodule : wb_irq_trigger

`default_nettype wire

// File: wb_sim_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_sim_defs.svh"

module wb_sim_top (
    input  logic                  clk_gen,
    input  logic                  rst_gen,      // async, active low
    input  logic [`WB_ADDR_W-1:0] wb_adr_i,
    input  logic [`WB_DATA_W-1:0] wb_dat_i,
    output logic [`WB_DATA_W-1:0] wb_dat_o,
    input  logic                  wb_we_i,
    input  logic [`WB_SEL_W-1:0]  wb_sel_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_cyc_i,
    output logic                  wb_ack_o,
    output logic                  wb_err_o,     // timeout pulse
    output logic                  msw_irq_o,
    output logic                  mext_irq_o
);

    // ----------------------------------------------------------------------
    // fabric to target links
    // ----------------------------------------------------------------------
    wb_slave_if bus_dmem ();   // data region
    wb_slave_if bus_io ();     // IO region
    wb_slave_if bus_irq ();    // trigger register

    // ----------------------------------------------------------------------
    // decode, merge and timeout
    // ----------------------------------------------------------------------
    wb_fabric_ctrl u_ctrl (
        .clk_gen  (clk_gen),
        .rst_gen  (rst_gen),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_we_i  (wb_we_i),
        .wb_sel_i (wb_sel_i),
        .wb_stb_i (wb_stb_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_ack_o (wb_ack_o),
        .wb_err_o (wb_err_o),
        .bus_dmem (bus_dmem),
        .bus_io   (bus_io),
        .bus_irq  (bus_irq)
    );

    // ----------------------------------------------------------------------
    // targets
    // ----------------------------------------------------------------------
    // data memory, ack seen DMEM_LATENCY+1 edges after start
    wb_latency_mem #(
        .MEM_BYTES (`DMEM_SIZE),
        .LATENCY   (`DMEM_LATENCY)
    ) u_dmem (
        .clk_gen (clk_gen),
        .rst_gen (rst_gen),
        .bus     (bus_dmem)
    );

    // IO memory, same block with a long delay
    wb_latency_mem #(
        .MEM_BYTES (`IOMEM_SIZE),
        .LATENCY   (`IOMEM_LATENCY)
    ) u_iomem (
        .clk_gen (clk_gen),
        .rst_gen (rst_gen),
        .bus     (bus_io)
    );

    // interrupt lines toward the core
    wb_irq_trigger u_irq (
        .clk_gen    (clk_gen),
        .rst_gen    (rst_gen),
        .bus        (bus_irq),
        .msw_irq_o  (msw_irq_o),
        .mext_irq_o (mext_irq_o)
    );

endmodule : wb_sim_top

`default_nettype wire

// File: tb_wb_sim.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_sim_defs.svh"

module tb_wb_sim;

    localparam int MAX_WAIT = 400;              // cycles before a transfer is given up
    localparam int TOK_W    = 8*24;             // test name field
    localparam int OP_W     = 8*8;              // read or write
    localparam int RESP_W   = 8*8;              // ack or err

    logic                  clk_gen;
    logic                  rst_gen;
    logic [`WB_ADDR_W-1:0] wb_adr;
    logic [`WB_DATA_W-1:0] wb_dat_w;
    logic [`WB_DATA_W-1:0] wb_dat_r;
    logic                  wb_we;
    logic [`WB_SEL_W-1:0]  wb_sel;
    logic                  wb_stb;
    logic                  wb_cyc;
    logic                  wb_ack;
    logic                  wb_err;
    logic                  msw_irq;
    logic                  mext_irq;

    int pass_cnt;
    int fail_cnt;

    wb_sim_top wb_sim_top_i (
        .clk_gen    (clk_gen),
        .rst_gen    (rst_gen),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_dat_w),
        .wb_dat_o   (wb_dat_r),
        .wb_we_i    (wb_we),
        .wb_sel_i   (wb_sel),
        .wb_stb_i   (wb_stb),
        .wb_cyc_i   (wb_cyc),
        .wb_ack_o   (wb_ack),
        .wb_err_o   (wb_err),
        .msw_irq_o  (msw_irq),
        .mext_irq_o (mext_irq)
    );

    initial begin
        clk_gen = 1'b0;
        forever #5 clk_gen = ~clk_gen;          // 10 ns period
    end

    // whole run stays far below this
    initial begin
        #1_000_000;
        $display("simulation stopped, the run took longer than 1 ms");
        $display("** FAIL **");
        $finish;
    end

    // ----------------------------------------------------------------------
    // expected edges from request start to response, per address map
    // ----------------------------------------------------------------------
    function automatic int expected_cycles(input logic [`WB_ADDR_W-1:0] adr,
                                           input logic is_ack);
        if (!is_ack) return `WB_TIMEOUT;                           // err pulse
        if (adr >= `DMEM_BASE && adr < `DMEM_BASE + `DMEM_SIZE)
            return `DMEM_LATENCY + 1;
        if (adr >= `IOMEM_BASE && adr < `IOMEM_BASE + `IOMEM_SIZE)
            return `IOMEM_LATENCY + 1;
        if (adr == `IRQ_TRIG_ADDR) return 1;                       // trigger acks next edge
        return 0;
    endfunction

    // ----------------------------------------------------------------------
    // classic wishbone master, one transfer
    // ----------------------------------------------------------------------
    task automatic bus_xfer(
        input  logic                  is_wr,
        input  logic [`WB_ADDR_W-1:0] adr,
        input  logic [`WB_DATA_W-1:0] dat,
        input  logic [`WB_SEL_W-1:0]  sel,
        output logic                  got_ack,
        output logic                  got_err,
        output logic [`WB_DATA_W-1:0] rdata,
        output int                    cycles
    );
        @(posedge clk_gen);
        #1;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_we    = is_wr;
        wb_sel   = sel;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        @(posedge clk_gen);                     // request start edge
        cycles  = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        rdata   = '0;
        while (!got_ack && !got_err && cycles < MAX_WAIT) begin
            @(negedge clk_gen);                 // mid cycle, outputs settled
            cycles++;
            got_ack = wb_ack;
            got_err = wb_err;
            rdata   = wb_dat_r;
        end
        @(posedge clk_gen);                     // edge that takes the response
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // golden file walk
    // ----------------------------------------------------------------------
    initial begin
        int                    fd;
        int                    rc;
        int                    cycles;
        int                    exp_cyc;
        int                    errs;             // mismatches in current test
        logic [TOK_W-1:0]      tok;
        logic [OP_W-1:0]       op;
        logic [RESP_W-1:0]     resp;
        logic [8*200-1:0]      rest;             // rest of a comment line
        logic [`WB_ADDR_W-1:0] adr;
        logic [`WB_DATA_W-1:0] wdat;
        logic [`WB_SEL_W-1:0]  sel;
        logic [`WB_DATA_W-1:0] exp_dat;
        logic [`WB_DATA_W-1:0] rdata;
        logic                  exp_msw;
        logic                  exp_mext;
        logic                  exp_ack;
        logic                  got_ack;
        logic                  got_err;
        logic                  is_rd;
        string                 name;

        rst_gen  = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_we    = 1'b0;
        wb_sel   = '0;
        wb_stb   = 1'b0;
        wb_cyc   = 1'b0;
        pass_cnt = 0;
        fail_cnt = 0;
        repeat (10) @(posedge clk_gen);
        #1 rst_gen = 1'b1;

        fd = $fopen("tb_wb_sim_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tb_wb_sim_golden.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                rc = $fscanf(fd, "%s", tok);
                if (rc != 1) break;                 // end of file
                if (tok == TOK_W'("#")) begin
                    rc = $fgets(rest, fd);          // column notes
                    continue;
                end
                name = $sformatf("%0s", tok);
                rc = $fscanf(fd, "%s %h %h %h %s %h %d %d", op, adr, wdat, sel,
                             resp, exp_dat, exp_msw, exp_mext);
                if (rc != 8) begin
                    $display("golden file line for %0s is incomplete", name);
                    fail_cnt++;
                    break;
                end
                is_rd   = (op == OP_W'("read"));
                exp_ack = (resp == RESP_W'("ack"));
                exp_cyc = expected_cycles(adr, exp_ack);
                bus_xfer(!is_rd, adr, wdat, sel, got_ack, got_err, rdata, cycles);
                errs = 0;
                if (!got_ack && !got_err) begin
                    $display("%0s got neither ack nor err within %0d cycles", name, MAX_WAIT);
                    errs++;
                end else begin
                    if ({got_ack, got_err} != {exp_ack, !exp_ack}) begin
                        $display("ERR %0s response expected %0s got %0s", name,
                                 exp_ack ? "ack" : "err", got_ack ? "ack" : "err");
                        errs++;
                    end
                    if (cycles != exp_cyc) begin
                        $display("ERR %0s cycles expected %0d got %0d", name, exp_cyc, cycles);
                        errs++;
                    end
                    if (is_rd && rdata !== exp_dat) begin
                        $display("ERR %0s rdata expected %08h got %08h", name, exp_dat, rdata);
                        errs++;
                    end
                end
                if (msw_irq !== exp_msw) begin
                    $display("ERR %0s msw_irq expected %0b got %0b", name, exp_msw, msw_irq);
                    errs++;
                end
                if (mext_irq !== exp_mext) begin
                    $display("ERR %0s mext_irq expected %0b got %0b", name, exp_mext, mext_irq);
                    errs++;
                end
                if (errs == 0) begin
                    pass_cnt++;
                    $display("ok   %0s", name);
                end else begin
                    fail_cnt++;
                    $display("bad  %0s, %0d mismatches", name, errs);
                end
            end
            $fclose(fd);
        end

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_wb_sim

`default_nettype wire

// File: tb_wb_sim_golden.txt
# name op addr wdata sel resp rdata msw mext
# addr wdata sel rdata in hex, resp is ack or err, msw and mext are 0 or 1
dm_wr_full   write 80000010 11223344 f ack 00000000 0 0
dm_rd_full   read  80000010 00000000 f ack 11223344 0 0
dm_wr_b0     write 80000010 aabbccdd 1 ack 00000000 0 0
dm_rd_b0     read  80000010 00000000 f ack 112233dd 0 0
dm_wr_b32    write 80000010 55667788 c ack 00000000 0 0
dm_rd_b32    read  80000010 00000000 f ack 556633dd 0 0
dm_wr_top    write 80001ffc cafef00d f ack 00000000 0 0
dm_wr_b21    write 80001ffc 12345678 6 ack 00000000 0 0
dm_rd_top    read  80001ffc 00000000 f ack ca34560d 0 0
io_wr_0      write f0000000 11111111 f ack 00000000 0 0
io_wr_1      write f0000004 22222222 f ack 00000000 0 0
io_wr_2      write f0000008 33333333 f ack 00000000 0 0
io_wr_3      write f000000c 44444444 f ack 00000000 0 0
io_wr_4      write f0000010 55555555 f ack 00000000 0 0
io_wr_5      write f0000014 66666666 f ack 00000000 0 0
io_wr_6      write f0000018 77777777 f ack 00000000 0 0
io_wr_7      write f000001c 88888888 f ack 00000000 0 0
io_rd_0      read  f0000000 00000000 f ack 11111111 0 0
io_rd_1      read  f0000004 00000000 f ack 22222222 0 0
io_rd_2      read  f0000008 00000000 f ack 33333333 0 0
io_rd_3      read  f000000c 00000000 f ack 44444444 0 0
io_rd_4      read  f0000010 00000000 f ack 55555555 0 0
io_rd_5      read  f0000014 00000000 f ack 66666666 0 0
io_rd_6      read  f0000018 00000000 f ack 77777777 0 0
io_rd_7      read  f000001c 00000000 f ack 88888888 0 0
irq_sw       write ff000000 00000008 f ack 00000000 1 0
irq_ext      write ff000000 00000800 f ack 00000000 0 1
irq_both     write ff000000 ffffffff f ack 00000000 1 1
err_unmapped read  00001000 00000000 f err 00000000 1 1
err_trig_rd  read  ff000000 00000000 f err 00000000 1 1
err_trig_prt write ff000000 00000000 7 err 00000000 1 1
irq_clr      write ff000000 fffff7f7 f ack 00000000 0 0
err_io_end   read  f0000020 00000000 f err 00000000 0 0

// File: flist.f
+incdir+.
wb_sim_pkg.sv
wb_slave_if.sv
wb_fabric_ctrl.sv
wb_latency_mem.sv
wb_irq_trigger.sv
wb_sim_top.sv
tb_wb_sim.sv

// File: run_sim.sh
#!/bin/sh
# build the wishbone fabric testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 --top-module tb_wb_sim -f flist.f \
    -o tb_wb_sim_bin > build.log 2>&1 \
    && ./obj_dir/tb_wb_sim_bin > sim.log 2>&1 \
    || echo "build or run returned an error, see build.log and sim.log"

# the log decides the result
grep -q '\*\* PASS \*\*' sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
